// File: cr_pkg.sv
// Clock recovery shared definitions
`default_nettype none

package cr_pkg;

  localparam int BW_W   = 8;
  localparam int LC_W   = 2;
  localparam int LANES  = 4;
  localparam int LVL_W  = 2;
  localparam int ADDR_W = 20;

  // Lane-count codes
  localparam logic [LC_W-1:0] LC_ONE  = 2'd0;
  localparam logic [LC_W-1:0] LC_TWO  = 2'd1;
  localparam logic [LC_W-1:0] LC_BAD  = 2'd2;
  localparam logic [LC_W-1:0] LC_FOUR = 2'd3;

  // DPCD addresses
  localparam logic [ADDR_W-1:0] DPCD_LINK_BW     = 20'h00100;
  localparam logic [ADDR_W-1:0] DPCD_TRAIN_PAT   = 20'h00102;
  localparam logic [ADDR_W-1:0] DPCD_LANE0_SET   = 20'h00103;
  localparam logic [ADDR_W-1:0] DPCD_LANE_STATUS = 20'h00202;
  localparam logic [ADDR_W-1:0] DPCD_ADJ_REQ     = 20'h00206;

  // TPS1, scrambling off
  localparam logic [7:0] TPS1_BYTE = 8'h21;

  typedef enum logic [1:0] {
    AUX_WRITE = 2'd0,
    AUX_READ  = 2'd1
  } aux_cmd_t;

  typedef enum logic [2:0] {
    REQ_SINK_CFG,
    REQ_TRAIN_PAT,
    REQ_DRIVE_SET,
    REQ_READ_STATUS,
    REQ_READ_ADJ
  } aux_kind_t;

  typedef enum logic [3:0] {
    CR_IDLE,
    CR_SINK_CFG,
    CR_TRAIN_PAT,
    CR_DRIVE_SET,
    CR_WAIT_TMR,
    CR_RD_STATUS,
    CR_WAIT_STATUS,
    CR_CHECK,
    CR_RD_ADJ,
    CR_WAIT_ADJ,
    CR_EQ,
    CR_CHK
  } cr_state_t;

endpackage

`default_nettype wire

// File: aux_req_if.sv
// AUX request channel
`timescale 1ns/1ps
`default_nettype none

interface aux_req_if;

  logic              req;
  cr_pkg::aux_kind_t kind;
  logic              done;
  logic              failed;

  modport ctrl
  (
    output req, kind,
    input  done, failed
  );

  modport gen
  (
    input  req, kind,
    output done, failed
  );

endinterface

`default_nettype wire

// File: cr_param_regs.sv
// Link parameter registers
`timescale 1ns/1ps
`default_nettype none

module cr_param_regs
(
  input  wire                                   clk,
  input  wire                                   rst_n,
  input  wire                                   cfg_vld,
  input  wire [cr_pkg::BW_W-1:0]                link_bw,
  input  wire [cr_pkg::LC_W-1:0]                link_lc,
  input  wire [cr_pkg::LVL_W-1:0]               max_vtg,
  input  wire [cr_pkg::LVL_W-1:0]               max_pre,
  input  wire                                   drive_vld,
  input  wire [cr_pkg::LANES*cr_pkg::LVL_W-1:0] vtg,
  input  wire [cr_pkg::LANES*cr_pkg::LVL_W-1:0] pre,
  input  wire                                   cr_done_vld,
  input  wire [cr_pkg::LANES-1:0]               cr_done,
  output logic [cr_pkg::BW_W-1:0]               bw_q,
  output logic [cr_pkg::LC_W-1:0]               lc_q,
  output logic [cr_pkg::LVL_W-1:0]              max_vtg_q,
  output logic [cr_pkg::LVL_W-1:0]              max_pre_q,
  output logic [cr_pkg::LANES*cr_pkg::LVL_W-1:0] vtg_q,
  output logic [cr_pkg::LANES*cr_pkg::LVL_W-1:0] pre_q,
  output logic [cr_pkg::LANES-1:0]              cr_done_q
);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bw_q      <= '0;
      lc_q      <= '0;
      max_vtg_q <= '0;
      max_pre_q <= '0;
      vtg_q     <= '0;
      pre_q     <= '0;
      cr_done_q <= '0;
    end
    else
    begin
      // Link setting from policy side
      if (cfg_vld)
      begin
        bw_q      <= link_bw;
        lc_q      <= link_lc;
        max_vtg_q <= max_vtg;
        max_pre_q <= max_pre;
      end
      // Latest requested drive levels
      if (drive_vld)
      begin
        vtg_q <= vtg;
        pre_q <= pre;
      end
      if (cr_done_vld)
        cr_done_q <= cr_done;
    end
  end

endmodule

`default_nettype wire

// File: aux_req_gen.sv
// AUX request generator
`timescale 1ns/1ps
`default_nettype none

module aux_req_gen
(
  input  wire                                   clk,
  input  wire                                   rst_n,
  aux_req_if.gen                                bus,
  input  wire [cr_pkg::BW_W-1:0]                bw_q,
  input  wire [cr_pkg::LC_W-1:0]                lc_q,
  input  wire [cr_pkg::LANES*cr_pkg::LVL_W-1:0] vtg_q,
  input  wire [cr_pkg::LANES*cr_pkg::LVL_W-1:0] pre_q,
  input  wire [cr_pkg::LVL_W-1:0]               max_vtg_q,
  input  wire [cr_pkg::LVL_W-1:0]               max_pre_q,
  output logic                                  aux_vld,
  output cr_pkg::aux_cmd_t                      aux_cmd,
  output logic [cr_pkg::ADDR_W-1:0]             aux_addr,
  output logic [7:0]                            aux_len,
  output logic [7:0]                            aux_data,
  input  wire                                   aux_ack,
  input  wire                                   aux_native_failed
);

  typedef enum logic [1:0] {G_IDLE, G_SEND, G_WAIT} gen_state_t;

  gen_state_t               state;
  logic [1:0]               byte_cnt;
  logic [1:0]               last_byte;
  logic [1:0]               drive_last;
  logic                     done_q;
  logic                     failed_q;
  logic [cr_pkg::LVL_W-1:0] lane_vtg;
  logic [cr_pkg::LVL_W-1:0] lane_pre;

  assign bus.done   = done_q;
  assign bus.failed = failed_q;
  assign aux_vld    = (state == G_SEND);

  // Drive byte lane follows the byte counter
  assign lane_vtg = vtg_q[byte_cnt*cr_pkg::LVL_W +: cr_pkg::LVL_W];
  assign lane_pre = pre_q[byte_cnt*cr_pkg::LVL_W +: cr_pkg::LVL_W];

  always_comb
  begin
    case (lc_q)
      cr_pkg::LC_ONE: drive_last = 2'd0;
      cr_pkg::LC_TWO: drive_last = 2'd1;
      // Four lanes, code 2 included
      default:        drive_last = 2'd3;
    endcase
  end

  ////////////////////
  // Request fields
  ////////////////////
  always_comb
  begin
    aux_cmd   = cr_pkg::AUX_WRITE;
    aux_addr  = cr_pkg::DPCD_LINK_BW;
    aux_len   = 8'd0;
    aux_data  = 8'h00;
    last_byte = 2'd0;
    case (bus.kind)
      cr_pkg::REQ_SINK_CFG:
      begin
        last_byte = 2'd2;
        aux_len   = 8'd2;
        case (byte_cnt)
          2'd0:    aux_data = bw_q;
          // Enhanced framing plus lane count
          2'd1:    aux_data = 8'h80 + {6'd0, lc_q} + 8'd1;
          default: aux_data = 8'h00;
        endcase
      end
      cr_pkg::REQ_TRAIN_PAT:
      begin
        aux_addr = cr_pkg::DPCD_TRAIN_PAT;
        aux_data = cr_pkg::TPS1_BYTE;
      end
      cr_pkg::REQ_DRIVE_SET:
      begin
        aux_addr  = cr_pkg::DPCD_LANE0_SET;
        last_byte = drive_last;
        aux_len   = {6'd0, drive_last};
        aux_data  = {2'b00, lane_pre == max_pre_q, lane_pre, lane_vtg == max_vtg_q, lane_vtg};
      end
      cr_pkg::REQ_READ_STATUS:
      begin
        aux_cmd  = cr_pkg::AUX_READ;
        aux_addr = cr_pkg::DPCD_LANE_STATUS;
        aux_len  = 8'd1;
      end
      cr_pkg::REQ_READ_ADJ:
      begin
        aux_cmd  = cr_pkg::AUX_READ;
        aux_addr = cr_pkg::DPCD_ADJ_REQ;
        aux_len  = 8'd1;
      end
      default:
      begin
        aux_cmd = cr_pkg::AUX_WRITE;
      end
    endcase
  end

  ////////////////////
  // Sequencing
  ////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= G_IDLE;
      byte_cnt <= 2'd0;
      done_q   <= 1'b0;
      failed_q <= 1'b0;
    end
    else
    begin
      done_q   <= 1'b0;
      failed_q <= 1'b0;
      case (state)
        G_IDLE:
        begin
          // req of the finished request is still up while its reply is reported
          if (bus.req && !done_q && !failed_q)
          begin
            byte_cnt <= 2'd0;
            state    <= G_SEND;
          end
        end
        G_SEND:
        begin
          if (byte_cnt == last_byte)
            state <= G_WAIT;
          else
            byte_cnt <= byte_cnt + 2'd1;
        end
        G_WAIT:
        begin
          // No timeout, the sink holds everything here
          if (aux_ack)
          begin
            done_q <= 1'b1;
            state  <= G_IDLE;
          end
          else if (aux_native_failed)
          begin
            failed_q <= 1'b1;
            state    <= G_IDLE;
          end
        end
        default:
        begin
          state <= G_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: cr_ctrl.sv
// Clock recovery sequencer
`timescale 1ns/1ps
`default_nettype none

module cr_ctrl
(
  input  wire                                    clk,
  input  wire                                    rst_n,
  aux_req_if.ctrl                                bus,
  input  wire                                    start_cr,
  input  wire                                    retry_drive,
  input  wire                                    cr_done_vld,
  input  wire                                    drive_vld,
  input  wire [cr_pkg::LC_W-1:0]                 lc_q,
  input  wire [cr_pkg::BW_W-1:0]                 bw_q,
  input  wire [cr_pkg::LANES*cr_pkg::LVL_W-1:0]  vtg_q,
  input  wire [cr_pkg::LANES*cr_pkg::LVL_W-1:0]  pre_q,
  input  wire [cr_pkg::LANES-1:0]                cr_done_q,
  output logic                                   ctr_start,
  input  wire                                    ctr_fire,
  output logic                                   phy_cfg_vld,
  output logic [cr_pkg::BW_W-1:0]                phy_bw,
  output logic [cr_pkg::LC_W-1:0]                phy_lc,
  output logic                                   eq_start,
  output logic [cr_pkg::LANES*cr_pkg::LVL_W-1:0] new_vtg,
  output logic [cr_pkg::LANES*cr_pkg::LVL_W-1:0] new_pre,
  output logic [cr_pkg::BW_W-1:0]                new_bw,
  output logic [cr_pkg::LC_W-1:0]                new_lc,
  output logic                                   chk_start,
  output logic [cr_pkg::LANES*cr_pkg::LVL_W-1:0] adj_vtg,
  output logic [cr_pkg::LANES*cr_pkg::LVL_W-1:0] adj_pre
);

  cr_pkg::cr_state_t state;
  logic              lanes_ok;

  assign ctr_start = (state == cr_pkg::CR_WAIT_TMR);
  assign eq_start  = (state == cr_pkg::CR_EQ);
  assign chk_start = (state == cr_pkg::CR_CHK);
  assign phy_bw    = bw_q;
  assign phy_lc    = lc_q;
  assign new_vtg   = vtg_q;
  assign new_pre   = pre_q;
  assign new_bw    = bw_q;
  assign new_lc    = lc_q;
  assign adj_vtg   = vtg_q;
  assign adj_pre   = pre_q;

  // Every active lane reports clock recovery
  always_comb
  begin
    case (lc_q)
      cr_pkg::LC_ONE:  lanes_ok = cr_done_q[0];
      cr_pkg::LC_TWO:  lanes_ok = &cr_done_q[1:0];
      cr_pkg::LC_FOUR: lanes_ok = &cr_done_q;
      default:         lanes_ok = 1'b0;
    endcase
  end

  always_comb
  begin
    bus.req  = 1'b1;
    bus.kind = cr_pkg::REQ_SINK_CFG;
    case (state)
      cr_pkg::CR_SINK_CFG:  bus.kind = cr_pkg::REQ_SINK_CFG;
      cr_pkg::CR_TRAIN_PAT: bus.kind = cr_pkg::REQ_TRAIN_PAT;
      cr_pkg::CR_DRIVE_SET: bus.kind = cr_pkg::REQ_DRIVE_SET;
      cr_pkg::CR_RD_STATUS: bus.kind = cr_pkg::REQ_READ_STATUS;
      cr_pkg::CR_RD_ADJ:    bus.kind = cr_pkg::REQ_READ_ADJ;
      default:              bus.req  = 1'b0;
    endcase
  end

  ////////////////////
  // State sequence
  ////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= cr_pkg::CR_IDLE;
      phy_cfg_vld <= 1'b0;
    end
    else
    begin
      phy_cfg_vld <= 1'b0;
      // failed only follows one of our own requests
      if (bus.failed)
        state <= cr_pkg::CR_IDLE;
      else
      begin
        case (state)
          cr_pkg::CR_IDLE:
          begin
            if (start_cr)
              state <= cr_pkg::CR_SINK_CFG;
            else if (retry_drive)
              state <= cr_pkg::CR_DRIVE_SET;
          end
          cr_pkg::CR_SINK_CFG:
          begin
            if (bus.done)
            begin
              phy_cfg_vld <= 1'b1;
              state       <= cr_pkg::CR_TRAIN_PAT;
            end
          end
          cr_pkg::CR_TRAIN_PAT:
            if (bus.done)
              state <= cr_pkg::CR_DRIVE_SET;
          cr_pkg::CR_DRIVE_SET:
            if (bus.done)
              state <= cr_pkg::CR_WAIT_TMR;
          cr_pkg::CR_WAIT_TMR:
            if (ctr_fire)
              state <= cr_pkg::CR_RD_STATUS;
          cr_pkg::CR_RD_STATUS:
            if (bus.done)
              state <= cr_pkg::CR_WAIT_STATUS;
          cr_pkg::CR_WAIT_STATUS:
            if (cr_done_vld)
              state <= cr_pkg::CR_CHECK;
          cr_pkg::CR_CHECK:
          begin
            if (lc_q == cr_pkg::LC_BAD)
              state <= cr_pkg::CR_IDLE;
            else if (lanes_ok)
              state <= cr_pkg::CR_EQ;
            else
              state <= cr_pkg::CR_RD_ADJ;
          end
          cr_pkg::CR_RD_ADJ:
            if (bus.done)
              state <= cr_pkg::CR_WAIT_ADJ;
          cr_pkg::CR_WAIT_ADJ:
            if (drive_vld)
              state <= cr_pkg::CR_CHK;
          default:
            state <= cr_pkg::CR_IDLE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: cr_top.sv
// Clock recovery top level
`timescale 1ns/1ps
`default_nettype none

module cr_top
(
  input  wire                                    clk,
  input  wire                                    rst_n,
  input  wire                                    start_cr,
  input  wire                                    retry_drive,
  input  wire                                    cfg_vld,
  input  wire [cr_pkg::BW_W-1:0]                 link_bw,
  input  wire [cr_pkg::LC_W-1:0]                 link_lc,
  input  wire [cr_pkg::LVL_W-1:0]                max_vtg,
  input  wire [cr_pkg::LVL_W-1:0]                max_pre,
  input  wire                                    drive_vld,
  input  wire [cr_pkg::LANES*cr_pkg::LVL_W-1:0]  vtg,
  input  wire [cr_pkg::LANES*cr_pkg::LVL_W-1:0]  pre,
  input  wire                                    cr_done_vld,
  input  wire [cr_pkg::LANES-1:0]                cr_done,
  output logic                                   aux_vld,
  output cr_pkg::aux_cmd_t                       aux_cmd,
  output logic [cr_pkg::ADDR_W-1:0]              aux_addr,
  output logic [7:0]                             aux_len,
  output logic [7:0]                             aux_data,
  input  wire                                    aux_ack,
  input  wire                                    aux_native_failed,
  output logic                                   ctr_start,
  input  wire                                    ctr_fire,
  output logic                                   phy_cfg_vld,
  output logic [cr_pkg::BW_W-1:0]                phy_bw,
  output logic [cr_pkg::LC_W-1:0]                phy_lc,
  output logic                                   eq_start,
  output logic [cr_pkg::LANES*cr_pkg::LVL_W-1:0] new_vtg,
  output logic [cr_pkg::LANES*cr_pkg::LVL_W-1:0] new_pre,
  output logic [cr_pkg::BW_W-1:0]                new_bw,
  output logic [cr_pkg::LC_W-1:0]                new_lc,
  output logic                                   chk_start,
  output logic [cr_pkg::LANES*cr_pkg::LVL_W-1:0] adj_vtg,
  output logic [cr_pkg::LANES*cr_pkg::LVL_W-1:0] adj_pre
);

  logic [cr_pkg::BW_W-1:0]                bw_q;
  logic [cr_pkg::LC_W-1:0]                lc_q;
  logic [cr_pkg::LVL_W-1:0]               max_vtg_q;
  logic [cr_pkg::LVL_W-1:0]               max_pre_q;
  logic [cr_pkg::LANES*cr_pkg::LVL_W-1:0] vtg_q;
  logic [cr_pkg::LANES*cr_pkg::LVL_W-1:0] pre_q;
  logic [cr_pkg::LANES-1:0]               cr_done_q;

  aux_req_if req_bus ();

  cr_param_regs param_regs_inst
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_vld     (cfg_vld),
    .link_bw     (link_bw),
    .link_lc     (link_lc),
    .max_vtg     (max_vtg),
    .max_pre     (max_pre),
    .drive_vld   (drive_vld),
    .vtg         (vtg),
    .pre         (pre),
    .cr_done_vld (cr_done_vld),
    .cr_done     (cr_done),
    .bw_q        (bw_q),
    .lc_q        (lc_q),
    .max_vtg_q   (max_vtg_q),
    .max_pre_q   (max_pre_q),
    .vtg_q       (vtg_q),
    .pre_q       (pre_q),
    .cr_done_q   (cr_done_q)
  );

  aux_req_gen req_gen_inst
  (
    .clk               (clk),
    .rst_n             (rst_n),
    .bus               (req_bus.gen),
    .bw_q              (bw_q),
    .lc_q              (lc_q),
    .vtg_q             (vtg_q),
    .pre_q             (pre_q),
    .max_vtg_q         (max_vtg_q),
    .max_pre_q         (max_pre_q),
    .aux_vld           (aux_vld),
    .aux_cmd           (aux_cmd),
    .aux_addr          (aux_addr),
    .aux_len           (aux_len),
    .aux_data          (aux_data),
    .aux_ack           (aux_ack),
    .aux_native_failed (aux_native_failed)
  );

  cr_ctrl ctrl_inst
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus         (req_bus.ctrl),
    .start_cr    (start_cr),
    .retry_drive (retry_drive),
    .cr_done_vld (cr_done_vld),
    .drive_vld   (drive_vld),
    .lc_q        (lc_q),
    .bw_q        (bw_q),
    .vtg_q       (vtg_q),
    .pre_q       (pre_q),
    .cr_done_q   (cr_done_q),
    .ctr_start   (ctr_start),
    .ctr_fire    (ctr_fire),
    .phy_cfg_vld (phy_cfg_vld),
    .phy_bw      (phy_bw),
    .phy_lc      (phy_lc),
    .eq_start    (eq_start),
    .new_vtg     (new_vtg),
    .new_pre     (new_pre),
    .new_bw      (new_bw),
    .new_lc      (new_lc),
    .chk_start   (chk_start),
    .adj_vtg     (adj_vtg),
    .adj_pre     (adj_pre)
  );

endmodule

`default_nettype wire

// File: tb_cr_top.sv
// Clock recovery testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cr_top;

  localparam int NROWS    = 8;
  localparam int LIMIT    = NROWS * 200;
  localparam int SETTLE   = 20;
  localparam int NO_FAIL  = -1;
  localparam int OUT_EQ   = 0;
  localparam int OUT_CHK  = 1;
  localparam int OUT_IDLE = 2;

  typedef struct packed {
    logic       start;
    logic [7:0] bw;
    logic [1:0] lc;
    logic [7:0] vtg;
    logic [7:0] pre;
    logic [1:0] max_vtg;
    logic [1:0] max_pre;
    logic [3:0] status;
    logic [7:0] adj_vtg;
    logic [7:0] adj_pre;
    int         fail_at;
    int         outcome;
  } row_t;

  logic              clk;
  logic              rst_n;
  logic              start_cr;
  logic              retry_drive;
  logic              cfg_vld;
  logic [7:0]        link_bw;
  logic [1:0]        link_lc;
  logic [1:0]        max_vtg;
  logic [1:0]        max_pre;
  logic              drive_vld;
  logic [7:0]        vtg;
  logic [7:0]        pre;
  logic              cr_done_vld;
  logic [3:0]        cr_done;
  logic              aux_vld;
  cr_pkg::aux_cmd_t  aux_cmd;
  logic [19:0]       aux_addr;
  logic [7:0]        aux_len;
  logic [7:0]        aux_data;
  logic              aux_ack;
  logic              aux_native_failed;
  logic              ctr_start;
  logic              ctr_fire;
  logic              phy_cfg_vld;
  logic [7:0]        phy_bw;
  logic [1:0]        phy_lc;
  logic              eq_start;
  logic [7:0]        new_vtg;
  logic [7:0]        new_pre;
  logic [7:0]        new_bw;
  logic [1:0]        new_lc;
  logic              chk_start;
  logic [7:0]        adj_vtg;
  logic [7:0]        adj_pre;

  // Stimulus table and expected AUX transactions of the current row
  row_t        rows [NROWS];
  row_t        cur;
  logic [1:0]  e_cmd [8];
  logic [19:0] e_addr [8];
  logic [7:0]  e_len [8];
  int          e_cnt [8];
  logic [7:0]  e_byte [8][4];

  int          n_exp;
  int          drive_idx;
  int          txn_idx;
  int          byte_idx;
  int          reply_idx;
  int          reply_cnt;
  int          data_cnt;
  int          fire_wait;
  int          fire_cnt;
  int          phy_cnt;
  int          cycles;
  logic        in_txn;
  logic        data_adj;
  logic        fire_armed;
  logic        eq_seen;
  logic        chk_seen;
  logic [31:0] lfsr;

  cr_top cr_top_inst (.*);

  always #50 clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("error: %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first error");
    end
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output int v);
    int i;
    v = 0;
    for (i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v    = v * 2 + (lfsr[0] ? 1 : 0);
    end
  endtask

  function automatic int lane_count(input logic [1:0] lc);
    case (lc)
      2'd0:    return 1;
      2'd1:    return 2;
      default: return 4;
    endcase
  endfunction

  // Lane drive byte with max-reached flags
  function automatic logic [7:0] drive_byte(input logic [1:0] v, input logic [1:0] p,
                                            input logic [1:0] mv, input logic [1:0] mp);
    logic [7:0] b;
    b      = 8'h00;
    b[1:0] = v;
    b[2]   = (v == mv);
    b[4:3] = p;
    b[5]   = (p == mp);
    return b;
  endfunction

  task automatic add_txn(input logic [1:0] cmd, input logic [19:0] addr,
                         input logic [7:0] len, input int cnt);
    int j;
    e_cmd[n_exp]  = cmd;
    e_addr[n_exp] = addr;
    e_len[n_exp]  = len;
    e_cnt[n_exp]  = cnt;
    for (j = 0; j < 4; j++)
      e_byte[n_exp][j] = 8'h00;
    n_exp++;
  endtask

  task automatic build_expected();
    int n;
    int i;
    n_exp = 0;
    if (cur.start)
    begin
      add_txn(2'd0, 20'h00100, 8'd2, 3);
      e_byte[0][0] = cur.bw;
      // Enhanced framing bit and lane count
      e_byte[0][1] = {1'b1, 4'd0, 3'(cur.lc) + 3'd1};
      add_txn(2'd0, 20'h00102, 8'd0, 1);
      e_byte[1][0] = 8'h21;
    end
    drive_idx = n_exp;
    n = lane_count(cur.lc);
    add_txn(2'd0, 20'h00103, 8'(n - 1), n);
    for (i = 0; i < n; i++)
      e_byte[drive_idx][i] = drive_byte(cur.vtg[2*i +: 2], cur.pre[2*i +: 2],
                                        cur.max_vtg, cur.max_pre);
    add_txn(2'd1, 20'h00202, 8'd1, 1);
    if (cur.outcome == OUT_CHK)
      add_txn(2'd1, 20'h00206, 8'd1, 1);
    if (cur.fail_at != NO_FAIL)
      n_exp = cur.fail_at + 1;
  endtask

  ////////////////////
  // One cycle with sink and timer model
  ////////////////////
  task automatic tick();
    int d;
    @(negedge clk);
    cycles++;
    if (cycles > LIMIT)
    begin
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped on timeout");
    end
    start_cr          = 1'b0;
    retry_drive       = 1'b0;
    cfg_vld           = 1'b0;
    drive_vld         = 1'b0;
    cr_done_vld       = 1'b0;
    aux_ack           = 1'b0;
    aux_native_failed = 1'b0;
    ctr_fire          = 1'b0;
    // Read data follows the ack
    if (data_cnt > 0)
    begin
      data_cnt--;
      if (data_cnt == 0)
      begin
        if (data_adj)
        begin
          drive_vld = 1'b1;
          vtg       = cur.adj_vtg;
          pre       = cur.adj_pre;
        end
        else
        begin
          cr_done_vld = 1'b1;
          cr_done     = cur.status;
        end
      end
    end
    if (aux_vld)
    begin
      if (txn_idx >= n_exp)
        check_val("aux_vld", 32'(aux_vld), 32'd0);
      if (!in_txn)
      begin
        check_val("aux_cmd", 32'(aux_cmd), 32'(e_cmd[txn_idx]));
        check_val("aux_addr", 32'(aux_addr), 32'(e_addr[txn_idx]));
        check_val("aux_len", 32'(aux_len), 32'(e_len[txn_idx]));
        in_txn   = 1'b1;
        byte_idx = 0;
      end
      if (byte_idx >= e_cnt[txn_idx])
        check_val("aux_vld", 32'(aux_vld), 32'd0);
      check_val("aux_data", 32'(aux_data), 32'(e_byte[txn_idx][byte_idx]));
      byte_idx++;
    end
    else if (in_txn)
    begin
      check_val("aux byte count", 32'(byte_idx), 32'(e_cnt[txn_idx]));
      in_txn = 1'b0;
      draw_bits(2, d);
      reply_cnt = d + 1;
      reply_idx = txn_idx;
      txn_idx++;
    end
    else if (reply_cnt > 0)
    begin
      reply_cnt--;
      if (reply_cnt == 0 && reply_idx == cur.fail_at)
        aux_native_failed = 1'b1;
      else if (reply_cnt == 0)
      begin
        aux_ack = 1'b1;
        if (e_cmd[reply_idx] == 2'd1)
        begin
          data_cnt = 3;
          data_adj = (e_addr[reply_idx] == 20'h00206);
        end
      end
    end
    // Wait timer
    if (ctr_start && !fire_armed)
    begin
      fire_armed = 1'b1;
      draw_bits(3, d);
      fire_wait = d + 1;
      fire_cnt++;
    end
    else if (fire_armed)
    begin
      // Held until the timer fires
      check_val("ctr_start", 32'(ctr_start), 32'd1);
      fire_wait--;
      if (fire_wait == 0)
      begin
        ctr_fire   = 1'b1;
        fire_armed = 1'b0;
      end
    end
    if (phy_cfg_vld)
    begin
      phy_cnt++;
      check_val("phy_bw", 32'(phy_bw), 32'(cur.bw));
      check_val("phy_lc", 32'(phy_lc), 32'(cur.lc));
    end
    if (eq_start)
    begin
      check_val("eq_start", 32'(eq_start), 32'(cur.outcome == OUT_EQ));
      check_val("new_bw", 32'(new_bw), 32'(cur.bw));
      check_val("new_lc", 32'(new_lc), 32'(cur.lc));
      check_val("new_vtg", 32'(new_vtg), 32'(cur.vtg));
      check_val("new_pre", 32'(new_pre), 32'(cur.pre));
      eq_seen = 1'b1;
    end
    if (chk_start)
    begin
      check_val("chk_start", 32'(chk_start), 32'(cur.outcome == OUT_CHK));
      check_val("adj_vtg", 32'(adj_vtg), 32'(cur.adj_vtg));
      check_val("adj_pre", 32'(adj_pre), 32'(cur.adj_pre));
      chk_seen = 1'b1;
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial
  begin
    int r;
    int exp_fire;
    // start bw lc vtg pre max_vtg max_pre status adj_vtg adj_pre fail_at outcome
    rows[0] = '{1'b1, 8'h0a, 2'd0, 8'h01, 8'h02, 2'd3, 2'd3, 4'h1, 8'h00, 8'h00, NO_FAIL, OUT_EQ};
    rows[1] = '{1'b1, 8'h14, 2'd3, 8'he4, 8'h1b, 2'd3, 2'd2, 4'hf, 8'h00, 8'h00, NO_FAIL, OUT_EQ};
    rows[2] = '{1'b1, 8'h06, 2'd1, 8'h00, 8'h00, 2'd3, 2'd3, 4'h1, 8'h05, 8'h01, NO_FAIL, OUT_CHK};
    // Retry row with the adjusted levels of the row before
    rows[3] = '{1'b0, 8'h06, 2'd1, 8'h05, 8'h01, 2'd3, 2'd3, 4'h3, 8'h00, 8'h00, NO_FAIL, OUT_EQ};
    rows[4] = '{1'b1, 8'h0a, 2'd3, 8'h55, 8'h00, 2'd1, 2'd0, 4'hf, 8'h00, 8'h00, 0, OUT_IDLE};
    rows[5] = '{1'b1, 8'h0a, 2'd1, 8'h0f, 8'h05, 2'd3, 2'd1, 4'h3, 8'h00, 8'h00, 2, OUT_IDLE};
    rows[6] = '{1'b1, 8'h14, 2'd0, 8'h02, 8'h01, 2'd2, 2'd3, 4'h1, 8'h00, 8'h00, NO_FAIL, OUT_EQ};
    rows[7] = '{1'b1, 8'h0a, 2'd2, 8'h1b, 8'he4, 2'd3, 2'd3, 4'hf, 8'h00, 8'h00, NO_FAIL, OUT_IDLE};
    clk               = 1'b0;
    rst_n             = 1'b0;
    start_cr          = 1'b0;
    retry_drive       = 1'b0;
    cfg_vld           = 1'b0;
    link_bw           = 8'h00;
    link_lc           = 2'd0;
    max_vtg           = 2'd0;
    max_pre           = 2'd0;
    drive_vld         = 1'b0;
    vtg               = 8'h00;
    pre               = 8'h00;
    cr_done_vld       = 1'b0;
    cr_done           = 4'h0;
    aux_ack           = 1'b0;
    aux_native_failed = 1'b0;
    ctr_fire          = 1'b0;
    lfsr              = 32'hd8e4;
    cycles            = 0;
    n_exp             = 0;
    txn_idx           = 0;
    reply_cnt         = 0;
    data_cnt          = 0;
    fire_armed        = 1'b0;
    in_txn            = 1'b0;
    cur               = rows[0];
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    tick();
    check_val("aux_vld", 32'(aux_vld), 32'd0);
    check_val("phy_cfg_vld", 32'(phy_cfg_vld), 32'd0);
    check_val("ctr_start", 32'(ctr_start), 32'd0);
    check_val("eq_start", 32'(eq_start), 32'd0);
    check_val("chk_start", 32'(chk_start), 32'd0);
    for (r = 0; r < NROWS; r++)
    begin
      cur = rows[r];
      build_expected();
      txn_idx  = 0;
      fire_cnt = 0;
      phy_cnt  = 0;
      eq_seen  = 1'b0;
      chk_seen = 1'b0;
      if (cur.start)
      begin
        cfg_vld   = 1'b1;
        link_bw   = cur.bw;
        link_lc   = cur.lc;
        max_vtg   = cur.max_vtg;
        max_pre   = cur.max_pre;
        drive_vld = 1'b1;
        vtg       = cur.vtg;
        pre       = cur.pre;
        tick();
        start_cr = 1'b1;
      end
      else
        retry_drive = 1'b1;
      if (cur.outcome == OUT_EQ)
        while (!eq_seen)
          tick();
      else if (cur.outcome == OUT_CHK)
        while (!chk_seen)
          tick();
      else
        while (txn_idx < n_exp || in_txn || reply_cnt != 0 || data_cnt != 0)
          tick();
      // Nothing else may follow the end of the row
      repeat (SETTLE) tick();
      exp_fire = (cur.fail_at == NO_FAIL || cur.fail_at > drive_idx) ? 1 : 0;
      check_val("aux transaction count", 32'(txn_idx), 32'(n_exp));
      check_val("phy_cfg_vld pulses", 32'(phy_cnt), 32'(cur.start && cur.fail_at != 0));
      check_val("ctr_start runs", 32'(fire_cnt), 32'(exp_fire));
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
cr_pkg.sv
aux_req_if.sv
cr_param_regs.sv
aux_req_gen.sv
cr_ctrl.sv
cr_top.sv
tb_cr_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_cr_top -o sim_cr

./obj_dir/sim_cr > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
